//--- tb.f
+incdir+rtl
rtl/ofdm_sample_pkg.sv
rtl/ofdm_frame_pkg.sv
rtl/meta_fifo.sv
rtl/cp_remover.sv
rtl/dft_core.sv
rtl/ofdm_demod.sv
verif/tb_clock_gen.sv
verif/tb_ofdm_demod.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the OFDM demodulator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_ofdm_demod -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1

//--- verif/tb_ofdm_demod.sv
`timescale 1ns/1ps
`include "ofdm_defines.svh"

module tb_ofdm_demod;
    import ofdm_sample_pkg::*;
    import ofdm_frame_pkg::*;

    localparam int N           = `OFDM_FFT_LEN;
    localparam int SHIFT       = `OFDM_TWIDDLE_SHIFT;
    localparam int GAP_CYCLES  = 70;
    localparam int N_SYMBOLS   = 14;
    localparam int CYCLE_LIMIT = N_SYMBOLS * 100 + 200;
    // cos and -sin of 2*pi*i/8, scaled by 64
    localparam int COS_TAB [8]  = '{64, 45, 0, -45, -64, -45, 0, 45};
    localparam int MSIN_TAB [8] = '{0, -45, -64, -45, 0, 45, 64, 45};

    typedef struct packed {
        bin_t      bin;
        out_user_t user;
        logic      last;
    } beat_t;

    logic        clk;
    logic        reset_n;
    sample_t     s_tdata;
    in_user_t    s_tuser;
    logic        s_tlast;
    logic        s_tvalid;
    logic        ssb_start;
    bin_t        m_tdata;
    out_user_t   m_tuser;
    logic        m_tlast;
    logic        m_tvalid;

    beat_t       exp_q [$];
    beat_t       exp_beat;
    logic        exp_present = 1'b0;
    logic        quiet = 1'b1;
    sample_t     body [N];
    logic [31:0] lfsr_q;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          beat_cnt = 0;
    int          sym_cnt = 0;
    int          test_cnt = 0;
    int          errs_mark;
    int          beats_mark;

    tb_clock_gen #(.PERIOD_NS(10.0), .RESET_CYCLES(5)) u_clock_gen (
        .clk_o    (clk),
        .reset_no (reset_n)
    );

    ofdm_demod u_dut (
        .clk_i       (clk),
        .reset_ni    (reset_n),
        .s_tdata_i   (s_tdata),
        .s_tuser_i   (s_tuser),
        .s_tlast_i   (s_tlast),
        .s_tvalid_i  (s_tvalid),
        .ssb_start_i (ssb_start),
        .m_tdata_o   (m_tdata),
        .m_tuser_o   (m_tuser),
        .m_tlast_o   (m_tlast),
        .m_tvalid_o  (m_tvalid)
    );

    // galois form, taps 32 31 29 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hD000_0001;
        end
        return n;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[i]   = lfsr_q[0];
        end
        return v;
    endfunction

    function automatic sample_t rand_sample();
        sample_t s;
        s.re = rand_byte();
        s.im = rand_byte();
        return s;
    endfunction

    // reference DFT of the current body, one expected beat per bin
    task automatic push_expected(input frame_meta_t meta);
        int    acc_re;
        int    acc_im;
        int    xr;
        int    xi;
        int    idx;
        beat_t b;
        for (int k = 0; k < N; k++) begin
            acc_re = 0;
            acc_im = 0;
            for (int n = 0; n < N; n++) begin
                xr     = $signed(body[n].re);
                xi     = $signed(body[n].im);
                idx    = (n * k) % N;
                acc_re += xr * COS_TAB[idx] - xi * MSIN_TAB[idx];
                acc_im += xr * MSIN_TAB[idx] + xi * COS_TAB[idx];
            end
            acc_re      = acc_re >>> SHIFT;
            acc_im      = acc_im >>> SHIFT;
            b.bin.re    = acc_re[`OFDM_BIN_W-1:0];
            b.bin.im    = acc_im[`OFDM_BIN_W-1:0];
            b.user.meta = meta;
            b.user.pbch = (meta.symbol == 4'd3) && (meta.subframe == 5'd0);
            b.last      = (k == N - 1);
            exp_q.push_back(b);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            s_tvalid  = 1'b0;
            s_tlast   = 1'b0;
            ssb_start = 1'b0;
        end
    endtask

    // pre_len junk samples come before the ssb pulse, which opens a fresh prefix
    task automatic send_symbol(input int cp_len, input int tail_len, input int pre_len,
                               input logic ssb, input frame_meta_t meta);
        in_user_t user;
        int       skip;
        int       total;
        skip        = pre_len + cp_len;
        total       = skip + N + tail_len;
        user.meta   = meta;
        user.cp_len = cp_len[`OFDM_CP_W-1:0];
        push_expected(meta);
        sym_cnt++;
        for (int i = 0; i < total; i++) begin
            @(negedge clk);
            if (i >= skip && i < skip + N) begin
                s_tdata = body[i - skip];
            end else begin
                s_tdata = rand_sample();
            end
            s_tuser   = user;
            s_tlast   = (i == total - 1);
            ssb_start = ssb && (i == pre_len);
            s_tvalid  = 1'b1;
        end
        idle(GAP_CYCLES);
    endtask

    task automatic fill_random();
        for (int n = 0; n < N; n++) begin
            body[n] = rand_sample();
        end
    endtask

    task automatic begin_test();
        errs_mark  = err_cnt;
        beats_mark = beat_cnt;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        test_cnt++;
        $display("test %0d %s: %0d beats, %0d errors", test_cnt, name,
                 beat_cnt - beats_mark, err_cnt - errs_mark);
    endtask

    // take the next expected beat while the DUT output is stable
    always @(negedge clk) begin
        exp_present = 1'b0;
        if (reset_n && m_tvalid) begin
            beat_cnt++;
            if (exp_q.size() > 0) begin
                exp_beat    = exp_q.pop_front();
                exp_present = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d expected bins never came out",
                     CYCLE_LIMIT, exp_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) quiet |-> !(m_tvalid || m_tlast))
        else begin
            err_cnt++;
            $display("output went active at %0t before any input was sent", $time);
        end

    assert property (@(posedge clk) disable iff (!reset_n) m_tvalid |-> exp_present)
        else begin
            err_cnt++;
            $display("output beat at %0t with no symbol outstanding", $time);
        end

    assert property (@(posedge clk) disable iff (!reset_n) m_tlast |-> m_tvalid)
        else begin
            err_cnt++;
            $display("m_tlast_o high without m_tvalid_o at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!reset_n)
        (m_tvalid && exp_present) |-> (m_tdata == exp_beat.bin))
        else begin
            err_cnt++;
            $display("Error: %0t m_tdata_o expected re %0d im %0d got re %0d im %0d", $time,
                     exp_beat.bin.re, exp_beat.bin.im,
                     $sampled(m_tdata.re), $sampled(m_tdata.im));
        end

    assert property (@(posedge clk) disable iff (!reset_n)
        (m_tvalid && exp_present) |-> (m_tuser == exp_beat.user))
        else begin
            err_cnt++;
            $display("Error: %0t m_tuser_o expected %h got %h", $time,
                     exp_beat.user, $sampled(m_tuser));
        end

    assert property (@(posedge clk) disable iff (!reset_n)
        (m_tvalid && exp_present) |-> (m_tlast == exp_beat.last))
        else begin
            err_cnt++;
            $display("Error: %0t m_tlast_o expected %b got %b", $time,
                     exp_beat.last, $sampled(m_tlast));
        end

    initial begin
        s_tdata   = '0;
        s_tuser   = '0;
        s_tlast   = 1'b0;
        s_tvalid  = 1'b0;
        ssb_start = 1'b0;
        lfsr_q    = 32'd92952;
        @(posedge reset_n);

        begin_test();
        idle(20);
        quiet = 1'b0;
        finish_test("quiet after reset");

        begin_test();
        for (int n = 0; n < N; n++) begin
            body[n] = '0;
        end
        body[0].re = 8'sd100;
        body[0].im = -8'sd20;
        send_symbol(2, 0, 0, 1'b0, {10'd1, 5'd2, 4'd0});
        for (int n = 0; n < N; n++) begin
            body[n].re = 8'sd30;
            body[n].im = -8'sd12;
        end
        send_symbol(3, 0, 0, 1'b0, {10'd1, 5'd2, 4'd1});
        fill_random();
        send_symbol(4, 0, 0, 1'b0, {10'd1, 5'd2, 4'd2});
        fill_random();
        send_symbol(2, 0, 0, 1'b0, {10'd1, 5'd2, 4'd3});
        finish_test("dft values");

        begin_test();
        fill_random();
        send_symbol(1, 0, 0, 1'b0, {10'd2, 5'd4, 4'd5});
        fill_random();
        send_symbol(3, 0, 0, 1'b0, {10'd2, 5'd4, 4'd6});
        fill_random();
        send_symbol(7, 0, 0, 1'b0, {10'd2, 5'd4, 4'd7});
        finish_test("cp removal");

        begin_test();
        fill_random();
        send_symbol(2, 5, 0, 1'b0, {10'd3, 5'd9, 4'd8});
        fill_random();
        send_symbol(3, 0, 0, 1'b0, {10'd3, 5'd9, 4'd9});
        finish_test("tail skip");

        begin_test();
        fill_random();
        send_symbol(2, 0, 0, 1'b0, {10'd0, 5'd0, 4'd2});
        fill_random();
        send_symbol(2, 0, 0, 1'b0, {10'd0, 5'd0, 4'd3});
        fill_random();
        send_symbol(2, 0, 0, 1'b0, {10'd1023, 5'd1, 4'd3});
        finish_test("metadata");

        begin_test();
        fill_random();
        send_symbol(5, 0, 2, 1'b1, {10'd7, 5'd0, 4'd10});
        fill_random();
        send_symbol(6, 0, 4, 1'b1, {10'd7, 5'd0, 4'd11});
        finish_test("ssb resync");

        if (beat_cnt != sym_cnt * N) begin
            err_cnt++;
            $display("got %0d bins for %0d symbols, expected %0d", beat_cnt, sym_cnt,
                     sym_cnt * N);
        end
        $display("tests %0d, symbols %0d, beats %0d, errors %0d",
                 test_cnt, sym_cnt, beat_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_no
);
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            clk_o = ~clk_o;
        end
    end

    // release on a falling edge, clear of the sampling edge
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_no = 1'b1;
    end

endmodule

//--- rtl/ofdm_demod.sv
`timescale 1ns/1ps

module ofdm_demod (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  ofdm_sample_pkg::sample_t  s_tdata_i,
    input  ofdm_frame_pkg::in_user_t  s_tuser_i,
    input  logic                      s_tlast_i,
    input  logic                      s_tvalid_i,
    input  logic                      ssb_start_i,
    output ofdm_sample_pkg::bin_t     m_tdata_o,
    output ofdm_frame_pkg::out_user_t m_tuser_o,
    output logic                      m_tlast_o,
    output logic                      m_tvalid_o
);
    import ofdm_sample_pkg::*;
    import ofdm_frame_pkg::*;

    sample_t     smp;
    logic        smp_valid;
    frame_meta_t meta_in;
    logic        meta_push;
    frame_meta_t meta_head;
    logic        meta_empty;
    logic        meta_pop;

    cp_remover u_cp_remover (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .s_tdata_i   (s_tdata_i),
        .s_tuser_i   (s_tuser_i),
        .s_tlast_i   (s_tlast_i),
        .s_tvalid_i  (s_tvalid_i),
        .ssb_start_i (ssb_start_i),
        .smp_o       (smp),
        .smp_valid_o (smp_valid),
        .meta_o      (meta_in),
        .meta_push_o (meta_push)
    );

    // frame info waits here while its symbol is transformed
    meta_fifo #(
        .payload_t (frame_meta_t)
    ) u_meta_fifo (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .push_i   (meta_push),
        .data_i   (meta_in),
        .pop_i    (meta_pop),
        .data_o   (meta_head),
        .empty_o  (meta_empty)
    );

    dft_core u_dft_core (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .smp_i       (smp),
        .smp_valid_i (smp_valid),
        .bin_o       (m_tdata_o),
        .bin_valid_o (m_tvalid_o),
        .bin_last_o  (m_tlast_o)
    );

    // metadata retires with the last bin of its symbol
    assign meta_pop = m_tlast_o;

    assign m_tuser_o.meta = meta_head;
    assign m_tuser_o.pbch = !meta_empty && is_pbch(meta_head);

endmodule

//--- rtl/dft_core.sv
`timescale 1ns/1ps
`include "ofdm_defines.svh"

module dft_core (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  ofdm_sample_pkg::sample_t smp_i,
    input  logic                     smp_valid_i,
    output ofdm_sample_pkg::bin_t    bin_o,
    output logic                     bin_valid_o,
    output logic                     bin_last_o
);
    import ofdm_sample_pkg::*;

    localparam int N     = `OFDM_FFT_LEN;
    localparam int IDX_W = `OFDM_NFFT;
    localparam int SHIFT = `OFDM_TWIDDLE_SHIFT;
    // product plus sign of the complex sum plus growth over 8 terms
    localparam int ACC_W = `OFDM_SAMPLE_W + TWIDDLE_W + IDX_W + 1;

    sample_t                      bank_q [2][N];
    logic [1:0]                   full_q;
    logic                         wr_bank_q;
    logic [IDX_W-1:0]             wr_idx_q;
    logic                         rd_bank_q;
    logic                         busy_q;
    logic [IDX_W-1:0]             n_q;
    logic [IDX_W-1:0]             k_q;
    logic signed [ACC_W-1:0]      acc_re_q;
    logic signed [ACC_W-1:0]      acc_im_q;

    sample_t                      x;
    logic signed [`OFDM_SAMPLE_W-1:0] x_re;
    logic signed [`OFDM_SAMPLE_W-1:0] x_im;
    logic [IDX_W-1:0]             tw_idx;
    logic signed [TWIDDLE_W-1:0]  w_re;
    logic signed [TWIDDLE_W-1:0]  w_im;
    logic signed [ACC_W-1:0]      sum_re;
    logic signed [ACC_W-1:0]      sum_im;
    logic signed [ACC_W-1:0]      sh_re;
    logic signed [ACC_W-1:0]      sh_im;
    logic                         start;
    logic                         bin_done;

    assign start    = !busy_q && full_q[rd_bank_q];
    assign bin_done = busy_q && (n_q == IDX_W'(N - 1));

    assign x    = bank_q[rd_bank_q][n_q];
    assign x_re = x.re;
    assign x_im = x.im;
    // n*k mod 8 falls out of the 3 bit product
    assign tw_idx = n_q * k_q;
    assign w_re   = twiddle_re(tw_idx);
    assign w_im   = twiddle_im(tw_idx);

    // one complex MAC per cycle
    assign sum_re = acc_re_q + x_re * w_re - x_im * w_im;
    assign sum_im = acc_im_q + x_re * w_im + x_im * w_re;
    assign sh_re  = sum_re >>> SHIFT;
    assign sh_im  = sum_im >>> SHIFT;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            full_q      <= '0;
            wr_bank_q   <= 1'b0;
            wr_idx_q    <= '0;
            rd_bank_q   <= 1'b0;
            busy_q      <= 1'b0;
            n_q         <= '0;
            k_q         <= '0;
            bin_valid_o <= 1'b0;
            bin_last_o  <= 1'b0;
        end else begin
            bin_valid_o <= bin_done;
            bin_last_o  <= bin_done && (k_q == IDX_W'(N - 1));
            if (smp_valid_i) begin
                wr_idx_q <= wr_idx_q + 1'b1;
                if (wr_idx_q == IDX_W'(N - 1)) begin
                    full_q[wr_bank_q] <= 1'b1;
                    wr_bank_q         <= !wr_bank_q;
                end
            end
            // n and k wrap back to zero at the end of each symbol
            if (start) begin
                busy_q <= 1'b1;
            end else if (busy_q) begin
                n_q <= n_q + 1'b1;
                if (bin_done) begin
                    k_q <= k_q + 1'b1;
                    if (k_q == IDX_W'(N - 1)) begin
                        busy_q            <= 1'b0;
                        full_q[rd_bank_q] <= 1'b0;
                        rd_bank_q         <= !rd_bank_q;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (smp_valid_i) begin
            bank_q[wr_bank_q][wr_idx_q] <= smp_i;
        end
        if (start) begin
            acc_re_q <= '0;
            acc_im_q <= '0;
        end else if (busy_q) begin
            if (bin_done) begin
                acc_re_q <= '0;
                acc_im_q <= '0;
                bin_o.re <= sh_re[`OFDM_BIN_W-1:0];
                bin_o.im <= sh_im[`OFDM_BIN_W-1:0];
            end else begin
                acc_re_q <= sum_re;
                acc_im_q <= sum_im;
            end
        end
    end

    // no ready upstream, so a third symbol would overwrite a pending bank
    assert property (@(posedge clk_i) disable iff (!reset_ni) smp_valid_i |-> !(&full_q))
        else $error("dft_core: sample arrived while both banks are full");

endmodule

//--- rtl/cp_remover.sv
`timescale 1ns/1ps
`include "ofdm_defines.svh"

module cp_remover (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  ofdm_sample_pkg::sample_t    s_tdata_i,
    input  ofdm_frame_pkg::in_user_t    s_tuser_i,
    input  logic                        s_tlast_i,
    input  logic                        s_tvalid_i,
    input  logic                        ssb_start_i,
    output ofdm_sample_pkg::sample_t    smp_o,
    output logic                        smp_valid_o,
    output ofdm_frame_pkg::frame_meta_t meta_o,
    output logic                        meta_push_o
);
    import ofdm_frame_pkg::*;

    typedef enum logic [1:0] {
        ST_CP,
        ST_BODY,
        ST_TAIL
    } state_t;

    state_t                  state_q;
    logic [`OFDM_CP_W-1:0]   cp_cnt_q;
    logic [`OFDM_CP_W-1:0]   cp_len_q;
    logic [`OFDM_NFFT-1:0]   body_cnt_q;
    logic                    first_q;
    frame_meta_t             meta_q;

    logic [`OFDM_CP_W-1:0]   cp_len_cur;
    logic [`OFDM_CP_W-1:0]   cp_base;
    logic                    body_acc;

    // the first sample of a symbol brings its own prefix length
    assign cp_len_cur = first_q ? s_tuser_i.cp_len : cp_len_q;
    // an ssb pulse restarts the prefix count on this very cycle
    assign cp_base = ssb_start_i ? '0 : cp_cnt_q;
    assign body_acc = s_tvalid_i && (state_q == ST_BODY);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= ST_CP;
            cp_cnt_q    <= '0;
            body_cnt_q  <= '0;
            first_q     <= 1'b1;
            smp_valid_o <= 1'b0;
            meta_push_o <= 1'b0;
        end else begin
            smp_valid_o <= body_acc;
            meta_push_o <= body_acc && (body_cnt_q == '0);
            if (s_tvalid_i) begin
                first_q <= s_tlast_i;
            end
            case (state_q)
                ST_CP: begin
                    if (s_tvalid_i) begin
                        if (cp_base == cp_len_cur - 1'b1) begin
                            state_q  <= ST_BODY;
                            cp_cnt_q <= '0;
                        end else begin
                            cp_cnt_q <= cp_base + 1'b1;
                        end
                    end else if (ssb_start_i) begin
                        cp_cnt_q <= '0;
                    end
                end
                ST_BODY: begin
                    if (s_tvalid_i) begin
                        if (body_cnt_q == `OFDM_NFFT'(`OFDM_FFT_LEN - 1)) begin
                            body_cnt_q <= '0;
                            state_q    <= s_tlast_i ? ST_CP : ST_TAIL;
                        end else begin
                            body_cnt_q <= body_cnt_q + 1'b1;
                        end
                    end
                end
                ST_TAIL: begin
                    // an early ssb pulse abandons the rest of the tail
                    if ((s_tvalid_i && s_tlast_i) || ssb_start_i) begin
                        state_q <= ST_CP;
                    end
                end
                default: begin
                    state_q <= ST_CP;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_tvalid_i) begin
            smp_o <= s_tdata_i;
        end
        if (s_tvalid_i && first_q) begin
            cp_len_q <= s_tuser_i.cp_len;
            meta_q   <= s_tuser_i.meta;
        end
        if (body_acc && (body_cnt_q == '0)) begin
            meta_o <= meta_q;
        end
    end

    // a symbol without a prefix would never leave cp skip cleanly
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (s_tvalid_i && first_q) |-> (s_tuser_i.cp_len != '0))
        else $error("cp_remover: zero cp length at start of symbol");

endmodule

//--- rtl/meta_fifo.sv
`timescale 1ns/1ps
`include "ofdm_defines.svh"

module meta_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_ni,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o
);
    localparam int DEPTH = `OFDM_META_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    payload_t       mem [DEPTH];
    logic [PTR_W:0] wr_ptr_q;
    logic [PTR_W:0] rd_ptr_q;
    logic           full;

    // extra pointer bit tells full from empty
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full    = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                     (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
    // head is visible without a read cycle
    assign data_o  = mem[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i && !full) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i && !empty_o) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !full) begin
            mem[wr_ptr_q[PTR_W-1:0]] <= data_i;
        end
    end

    // more symbols in flight than the dft can hold
    assert property (@(posedge clk_i) disable iff (!reset_ni) push_i |-> !full)
        else $error("meta_fifo: push while full");

    // a bin burst finished with no metadata queued for it
    assert property (@(posedge clk_i) disable iff (!reset_ni) pop_i |-> !empty_o)
        else $error("meta_fifo: pop while empty");

endmodule

//--- rtl/ofdm_frame_pkg.sv
`include "ofdm_defines.svh"

package ofdm_frame_pkg;

    // frame position of one OFDM symbol
    typedef struct packed {
        logic [9:0] sfn;
        logic [4:0] subframe;
        logic [3:0] symbol;
    } frame_meta_t;

    // side information on the input stream
    typedef struct packed {
        frame_meta_t            meta;
        logic [`OFDM_CP_W-1:0]  cp_len;
    } in_user_t;

    // side information on the bin stream
    typedef struct packed {
        frame_meta_t meta;
        logic        pbch;
    } out_user_t;

    // PBCH sits in symbol 3 of subframe 0
    function automatic logic is_pbch(input frame_meta_t meta);
        is_pbch = (meta.symbol == 4'd3) && (meta.subframe == 5'd0);
    endfunction

endpackage

//--- rtl/ofdm_sample_pkg.sv
`include "ofdm_defines.svh"

package ofdm_sample_pkg;

    parameter int TWIDDLE_W = 8;

    typedef struct packed {
        logic signed [`OFDM_SAMPLE_W-1:0] im;
        logic signed [`OFDM_SAMPLE_W-1:0] re;
    } sample_t;

    typedef struct packed {
        logic signed [`OFDM_BIN_W-1:0] im;
        logic signed [`OFDM_BIN_W-1:0] re;
    } bin_t;

    // cos(2*pi*idx/8) * 64, rounded
    function automatic logic signed [TWIDDLE_W-1:0] twiddle_re(input logic [`OFDM_NFFT-1:0] idx);
        case (idx)
            3'd0:       twiddle_re = 8'sd64;
            3'd1, 3'd7: twiddle_re = 8'sd45;
            3'd2, 3'd6: twiddle_re = 8'sd0;
            3'd3, 3'd5: twiddle_re = -8'sd45;
            default:    twiddle_re = -8'sd64;
        endcase
    endfunction

    // -sin(2*pi*idx/8) * 64, rounded
    function automatic logic signed [TWIDDLE_W-1:0] twiddle_im(input logic [`OFDM_NFFT-1:0] idx);
        case (idx)
            3'd0, 3'd4: twiddle_im = 8'sd0;
            3'd1, 3'd3: twiddle_im = -8'sd45;
            3'd2:       twiddle_im = -8'sd64;
            3'd5, 3'd7: twiddle_im = 8'sd45;
            default:    twiddle_im = 8'sd64;
        endcase
    endfunction

endpackage

//--- rtl/ofdm_defines.svh
`ifndef OFDM_DEFINES_SVH
`define OFDM_DEFINES_SVH

// log2 of the transform size
`define OFDM_NFFT 3

// points per symbol body
`define OFDM_FFT_LEN 8

// width of each real and imaginary input part
`define OFDM_SAMPLE_W 8

// width of each real and imaginary output part
`define OFDM_BIN_W 14

// twiddles are scaled by 64, so each bin drops 6 bits
`define OFDM_TWIDDLE_SHIFT 6

// cyclic prefix length field
`define OFDM_CP_W 3

// symbols in flight between cp remover and dft output
`define OFDM_META_DEPTH 4

`endif
